// File: hw/fm_reg_macros.svh
// Sizes are fixed by the OPM slot layout; changing them breaks the {op, ch} slot packing
`ifndef FM_REG_MACROS_SVH
`define FM_REG_MACROS_SVH

// One slot per operator of every channel
`define FM_SLOTS    32
`define FM_CHANNELS 8
`define FM_OPS      4

// Worst case for a pending write, in cen cycles
// 32 cycles for the operator ring to come round, plus the busy release
// and one cycle of slack
`define FM_WR_TIMEOUT 34

`endif

// File: hw/fm_reg_pkg.sv
// Field widths follow the OPM register map; data bytes carry the OPM bit packing
package fm_reg_pkg;

    typedef logic [4:0] slot_t;    // {op, ch}
    typedef logic [2:0] chan_t;
    typedef logic [1:0] opsel_t;   // 0 M1, 1 M2, 2 C1, 3 C2
    typedef logic [2:0] alg_t;

    typedef enum logic [3:0] {
        RL_FB_CON, KC, KF, PMS_AMS,                          // Channel fields
        DT1_MUL, TL, KS_AR, AMSEN_D1R, DT2_D2R, D1L_RR,      // Operator fields
        KEYON
    } reg_field_e;

    typedef enum logic {IDLE, PENDING} ctrl_state_e;

    typedef struct packed {
        logic [2:0] dt1;
        logic [3:0] mul;
        logic [6:0] tl;
        logic [1:0] ks;
        logic [4:0] arate;
        logic       amsen;
        logic [4:0] rate1;
        logic [1:0] dt2;
        logic [4:0] rate2;
        logic [3:0] d1l;
        logic [3:0] rrate;
    } op_par_t;

    typedef struct packed {
        logic [1:0] rl;
        logic [2:0] fb;
        alg_t       con;
        logic [6:0] kc;
        logic [5:0] kf;
        logic [2:0] pms;
        logic [1:0] ams;
    } ch_par_t;

    typedef struct packed {
        logic from_m1;
        logic from_m2;
        logic from_c1;
        logic carrier;
    } route_t;

    typedef struct packed {
        reg_field_e field;
        opsel_t     op;
        chan_t      ch;
        logic [7:0] data;
    } wr_req_t;

endpackage

// File: hw/fm_slot_ctrl.sv
// One write pending at a time; writes arriving while busy are dropped, not queued
module fm_slot_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cen,
    input  logic                   wr,
    input  fm_reg_pkg::wr_req_t    wr_req,
    output fm_reg_pkg::slot_t      cycles,
    output logic                   zero,
    output logic                   half,
    output logic                   busy,
    output logic                   op_up,
    output logic                   ch_up,
    output fm_reg_pkg::reg_field_e up_field,
    output logic [7:0]             up_data,
    output logic                   kon_wr,
    output fm_reg_pkg::wr_req_t    kon_req
);
    import fm_reg_pkg::*;

    ctrl_state_e state;
    wr_req_t     req_q;      // Write waiting for its slot
    logic        accept;
    logic        is_op;
    logic        head_hit;
    logic        update;

    function automatic logic op_field(reg_field_e f);
        return f inside {DT1_MUL, TL, KS_AR, AMSEN_D1R, DT2_D2R, D1L_RR};
    endfunction

    assign accept = wr && !busy;
    assign busy   = (state == PENDING);

    // Key-on bypasses the pending path entirely
    assign kon_wr  = accept && (wr_req.field == KEYON);
    assign kon_req = wr_req;

    // Operator fields wait for the exact slot, channel fields for any slot of the channel
    assign is_op    = op_field(req_q.field);
    assign head_hit = is_op ? (cycles == {req_q.op, req_q.ch})
                            : (cycles[2:0] == req_q.ch);
    assign update   = busy && cen && head_hit;

    assign op_up    = update && is_op;
    assign ch_up    = update && !is_op;
    assign up_field = req_q.field;
    assign up_data  = req_q.data;

    assign zero = (cycles == 5'd0);
    assign half = (cycles[3:0] == 4'd0);   // Slots 0 and 16

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cycles <= '0;
        end else if (cen) begin
            cycles <= cycles + 5'd1;           // Wraps 31 to 0
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (accept && wr_req.field != KEYON) begin
                        state <= PENDING;
                    end
                end
                PENDING: begin
                    if (update) begin
                        state <= IDLE;     // Busy drops on the clock after the strobe
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= wr_req;
        end
    end

endmodule

// File: hw/fm_op_regs.sv
// Ring stays aligned to the slot counter only if both see the same reset and cen
`include "fm_reg_macros.svh"

module fm_op_regs (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cen,
    input  logic                   op_up,
    input  fm_reg_pkg::reg_field_e up_field,
    input  logic [7:0]             up_data,
    output fm_reg_pkg::op_par_t    op_par
);
    import fm_reg_pkg::*;

    op_par_t ring [`FM_SLOTS];   // Entry 0 is the current slot
    op_par_t head_new;

    // Replace only the fields carried by one register byte
    function automatic op_par_t merge(op_par_t cur, reg_field_e f, logic [7:0] d);
        op_par_t p;
        p = cur;
        case (f)
            DT1_MUL: begin
                p.dt1 = d[6:4];
                p.mul = d[3:0];
            end
            TL: p.tl = d[6:0];
            KS_AR: begin
                p.ks    = d[7:6];
                p.arate = d[4:0];
            end
            AMSEN_D1R: begin
                p.amsen = d[7];
                p.rate1 = d[4:0];
            end
            DT2_D2R: begin
                p.dt2   = d[7:6];
                p.rate2 = d[4:0];
            end
            D1L_RR: begin
                p.d1l   = d[7:4];
                p.rrate = d[3:0];
            end
            default: p = cur;    // Channel fields and key-on never land here
        endcase
        return p;
    endfunction

    assign head_new = op_up ? merge(ring[0], up_field, up_data) : ring[0];
    assign op_par   = ring[0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `FM_SLOTS; i++) begin
                ring[i] <= '0;
            end
        end else if (cen) begin
            for (int i = 0; i < `FM_SLOTS - 1; i++) begin
                ring[i] <= ring[i + 1];
            end
            ring[`FM_SLOTS - 1] <= head_new;   // Head goes round to the tail
        end
    end

endmodule

// File: hw/fm_ch_regs.sv
// Eight entries rotate once per channel step, so every operator slot of a channel sees it
`include "fm_reg_macros.svh"

module fm_ch_regs (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cen,
    input  logic                   ch_up,
    input  fm_reg_pkg::reg_field_e up_field,
    input  logic [7:0]             up_data,
    output fm_reg_pkg::ch_par_t    ch_par
);
    import fm_reg_pkg::*;

    ch_par_t ring [`FM_CHANNELS];   // Entry 0 matches cycles[2:0]
    ch_par_t head_new;

    function automatic ch_par_t merge(ch_par_t cur, reg_field_e f, logic [7:0] d);
        ch_par_t p;
        p = cur;
        case (f)
            RL_FB_CON: begin
                p.rl  = d[7:6];
                p.fb  = d[5:3];
                p.con = d[2:0];
            end
            KC: p.kc = d[6:0];
            KF: p.kf = d[7:2];      // Low two bits unused
            PMS_AMS: begin
                p.pms = d[6:4];
                p.ams = d[1:0];
            end
            default: p = cur;
        endcase
        return p;
    endfunction

    assign head_new = ch_up ? merge(ring[0], up_field, up_data) : ring[0];
    assign ch_par   = ring[0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `FM_CHANNELS; i++) begin
                ring[i] <= '0;
            end
        end else if (cen) begin
            for (int i = 0; i < `FM_CHANNELS - 1; i++) begin
                ring[i] <= ring[i + 1];
            end
            ring[`FM_CHANNELS - 1] <= head_new;
        end
    end

endmodule

// File: hw/fm_keyon.sv
// Key-on writes apply at once, even with cen low; mask bit 3+n keys operator n of the channel
`include "fm_reg_macros.svh"

module fm_keyon (
    input  logic                clk,
    input  logic                rst,
    input  logic                cen,
    input  fm_reg_pkg::slot_t   cycles,
    input  logic                kon_wr,
    input  fm_reg_pkg::wr_req_t kon_req,
    input  logic                csm,
    input  logic                overflow_a,
    output logic                keyon
);

    logic [`FM_SLOTS-1:0] kon_q;     // Indexed by {op, ch}
    logic [4:0]           csm_cnt;   // Slots seen in the CSM round
    logic                 csm_on;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            kon_q <= '0;
        end else if (kon_wr) begin
            for (int i = 0; i < `FM_OPS; i++) begin
                kon_q[i * `FM_CHANNELS + int'(kon_req.data[2:0])] <= kon_req.data[3 + i];
            end
        end
    end

    // A new overflow restarts the round
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            csm_on  <= 1'b0;
            csm_cnt <= '0;
        end else if (overflow_a && csm) begin
            csm_on  <= 1'b1;
            csm_cnt <= '0;
        end else if (csm_on && cen) begin
            csm_cnt <= csm_cnt + 5'd1;
            if (csm_cnt == 5'(`FM_SLOTS - 1)) begin
                csm_on <= 1'b0;        // Full round done
            end
        end
    end

    assign keyon = csm_on || kon_q[cycles];

endmodule

// File: hw/fm_mod_route.sv
// Pure decode; M1 self-feedback is signalled through fb, not through these flags
module fm_mod_route (
    input  fm_reg_pkg::alg_t   con,
    input  fm_reg_pkg::opsel_t cur_op,
    output fm_reg_pkg::route_t route
);

    always_comb begin
        route = '0;
        case (cur_op)
            2'd0: begin                                   // M1
                route.carrier = (con == 3'd7);
            end
            2'd1: begin                                   // M2
                route.from_m1 = (con == 3'd1) || (con == 3'd5);
                route.from_c1 = (con <= 3'd2);
                route.carrier = (con >= 3'd5);
            end
            2'd2: begin                                   // C1
                // Fed by M1 except in algorithms 1, 2 and 7
                route.from_m1 = (con != 3'd1) && (con != 3'd2) && (con != 3'd7);
                route.carrier = (con >= 3'd4);
            end
            2'd3: begin                                   // C2
                route.from_m1 = (con == 3'd2) || (con == 3'd5);
                route.from_m2 = (con <= 3'd4);
                route.from_c1 = (con == 3'd3);
                route.carrier = 1'b1;                     // Always an output
            end
            default: route = '0;
        endcase
    end

endmodule

// File: hw/fm_reg_top.sv
// All slot outputs refer to cycles on the same clock; no pipeline stage offsets
module fm_reg_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                cen,
    input  logic                wr,
    input  fm_reg_pkg::wr_req_t wr_req,
    input  logic                csm,
    input  logic                overflow_a,
    output logic                busy,
    output fm_reg_pkg::slot_t   cycles,
    output logic                zero,
    output logic                half,
    output fm_reg_pkg::op_par_t op_par,
    output fm_reg_pkg::ch_par_t ch_par,
    output fm_reg_pkg::route_t  route,
    output logic                keyon
);
    import fm_reg_pkg::*;

    logic       op_up;
    logic       ch_up;
    reg_field_e up_field;
    logic [7:0] up_data;
    logic       kon_wr;
    wr_req_t    kon_req;

    fm_slot_ctrl u_ctrl (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .wr       (wr),
        .wr_req   (wr_req),
        .cycles   (cycles),
        .zero     (zero),
        .half     (half),
        .busy     (busy),
        .op_up    (op_up),
        .ch_up    (ch_up),
        .up_field (up_field),
        .up_data  (up_data),
        .kon_wr   (kon_wr),
        .kon_req  (kon_req)
    );

    fm_op_regs u_op_regs (.clk(clk), .rst(rst), .cen(cen), .op_up(op_up),
                          .up_field(up_field), .up_data(up_data), .op_par(op_par));

    fm_ch_regs u_ch_regs (.clk(clk), .rst(rst), .cen(cen), .ch_up(ch_up),
                          .up_field(up_field), .up_data(up_data), .ch_par(ch_par));

    fm_keyon u_keyon (.clk(clk), .rst(rst), .cen(cen), .cycles(cycles),
                      .kon_wr(kon_wr), .kon_req(kon_req), .csm(csm),
                      .overflow_a(overflow_a), .keyon(keyon));

    // Operator of the current slot sits in the top two bits
    fm_mod_route u_route (.con(ch_par.con), .cur_op(cycles[4:3]), .route(route));

endmodule

// File: tb/fm_reg_sva.sv
// Timing rules only; the write bound counts cen cycles from the rise of busy
`include "fm_reg_macros.svh"

module fm_reg_sva (
    input logic              clk,
    input logic              rst,
    input logic              cen,
    input logic              busy,
    input fm_reg_pkg::slot_t cycles,
    input logic              zero,
    input logic              half
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned busy_cen;   // cen cycles spent pending
    int unsigned fail_cnt;   // Failed assertions so far

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy_cen <= 0;
        end else begin
            busy_cen <= busy ? busy_cen + cen : 0;
        end
    end

    a_busy_bound: assert property (@(posedge clk) disable iff (rst) busy_cen <= `FM_WR_TIMEOUT)
        else begin
            fail_cnt++;
            $error("write pending longer than the timeout bound");
        end

    a_slot_step: assert property (@(posedge clk) disable iff (rst)
        cen |=> cycles == $past(cycles) + 5'd1)
        else begin
            fail_cnt++;
            $error("slot counter did not step on cen");
        end

    a_slot_hold: assert property (@(posedge clk) disable iff (rst) !cen |=> $stable(cycles))
        else begin
            fail_cnt++;
            $error("slot counter moved without cen");
        end

    a_flags: assert property (@(posedge clk) disable iff (rst)
        zero == (cycles == 5'd0) && half == (cycles[3:0] == 4'd0))
        else begin
            fail_cnt++;
            $error("zero or half disagrees with the slot counter");
        end

    a_reset: assert property (@(posedge clk) rst |=> cycles == 5'd0 && !busy)
        else begin
            fail_cnt++;
            $error("slot counter or busy not cleared by reset");
        end

endmodule

// File: tb/fm_reg_tb.sv
// Fixed seed for cen and write data; outputs are compared on every clock even while cen is low
`include "fm_reg_macros.svh"

module fm_reg_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import fm_reg_pkg::*;

    localparam int N_WRITES   = 64;    // Number of writes with each observation window as one
    localparam int MAX_CYCLES = N_WRITES * `FM_WR_TIMEOUT * 2 + 500;   // cen is high ~3/4

    logic    clk, rst, cen, wr, csm, overflow_a;
    wr_req_t wr_req;
    logic    busy, zero, half, keyon;
    slot_t   cycles;
    op_par_t op_par;
    ch_par_t ch_par;
    route_t  route;

    integer  seed = 32'h7671;
    string   test_name = "reset";
    int      val_errs;
    int      lat_errs;
    int      cyc_count;

    // Reference model stepped at every falling edge
    op_par_t op_sh [`FM_SLOTS];
    ch_par_t ch_sh [`FM_CHANNELS];
    logic    kon_sh [`FM_SLOTS];
    slot_t   exp_slot;
    logic    pend;          // Expected busy
    wr_req_t pend_req;
    int      csm_left;      // cen cycles left in the CSM round

    bind fm_reg_top fm_reg_sva u_sva (.*);

    fm_reg_top i_fm_reg_top (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        cen = 1'b0;
        forever begin
            @(posedge clk);
            cyc_count++;
            #10;
            cen = ($random(seed) & 3) != 0;   // High about three quarters of the time
        end
    end

    initial begin
        wait (cyc_count >= MAX_CYCLES);
        $display("Run hung: stimulus did not finish within %0d clock cycles", MAX_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    // e holds the edges M1>C1 M1>M2 C1>M2 M1>C2 M2>C2 C1>C2 from bit 5 down
    // car has one bit per operator
    function automatic route_t exp_route(alg_t a, opsel_t op);
        logic [5:0] e;
        logic [3:0] car;
        route_t     r;
        case (a)
            3'd0: {e, car} = {6'b101010, 4'b1000};
            3'd1: {e, car} = {6'b011010, 4'b1000};
            3'd2: {e, car} = {6'b001110, 4'b1000};
            3'd3: {e, car} = {6'b100011, 4'b1000};
            3'd4: {e, car} = {6'b100010, 4'b1100};
            3'd5: {e, car} = {6'b110100, 4'b1110};
            3'd6: {e, car} = {6'b100000, 4'b1110};
            default: {e, car} = {6'b000000, 4'b1111};
        endcase
        r.from_m1 = (op == 2'd1 && e[4]) || (op == 2'd2 && e[5]) || (op == 2'd3 && e[2]);
        r.from_m2 = (op == 2'd3 && e[1]);
        r.from_c1 = (op == 2'd1 && e[3]) || (op == 2'd3 && e[0]);
        r.carrier = car[op];
        return r;
    endfunction

    function automatic op_par_t exp_op(slot_t s);
        return op_sh[s];
    endfunction

    function automatic ch_par_t exp_ch(slot_t s);
        return ch_sh[s[2:0]];
    endfunction

    function automatic logic hits_head(wr_req_t q, slot_t s);
        return (q.field inside {RL_FB_CON, KC, KF, PMS_AMS}) ? (s[2:0] == q.ch)
                                                             : (s == {q.op, q.ch});
    endfunction

    // Register byte layout as in the OPM map
    task automatic apply_write(wr_req_t q);
        op_par_t p;
        ch_par_t c;
        p = op_sh[{q.op, q.ch}];
        c = ch_sh[q.ch];
        case (q.field)
            RL_FB_CON: {c.rl, c.fb, c.con} = q.data;
            KC:        c.kc = q.data[6:0];
            KF:        c.kf = q.data[7:2];
            PMS_AMS:   {c.pms, c.ams} = {q.data[6:4], q.data[1:0]};
            DT1_MUL:   {p.dt1, p.mul} = q.data[6:0];
            TL:        p.tl = q.data[6:0];
            KS_AR:     {p.ks, p.arate} = {q.data[7:6], q.data[4:0]};
            AMSEN_D1R: {p.amsen, p.rate1} = {q.data[7], q.data[4:0]};
            DT2_D2R:   {p.dt2, p.rate2} = {q.data[7:6], q.data[4:0]};
            D1L_RR:    {p.d1l, p.rrate} = q.data;
            default: begin
                for (int i = 0; i < `FM_OPS; i++) begin
                    kon_sh[i * `FM_CHANNELS + q.data[2:0]] = q.data[3 + i];
                end
            end
        endcase
        op_sh[{q.op, q.ch}] = p;
        ch_sh[q.ch]         = c;
    endtask

    task automatic report(string tag, string what, logic [63:0] exp, logic [63:0] act);
        val_errs++;
        $display("ERROR %s: %s expected %h, got %h", tag, what, exp, act);
    endtask

    task automatic check_op(string tag, op_par_t exp, op_par_t act);
        if (act !== exp) report(tag, "op_par", exp, act);
    endtask

    task automatic check_ch(string tag, ch_par_t exp, ch_par_t act);
        if (act !== exp) report(tag, "ch_par", exp, act);
    endtask

    task automatic check_route(string tag, route_t exp, route_t act);
        if (act !== exp) report(tag, "route", exp, act);
    endtask

    task automatic check_slot(string tag, slot_t exp, slot_t act);
        if (act !== exp) report(tag, "cycles", exp, act);
    endtask

    task automatic check_keyon(string tag, logic exp, logic act);
        if (act !== exp) report(tag, "keyon", exp, act);
    endtask

    task automatic check_flag(string tag, string what, logic exp, logic act);
        if (act !== exp) report(tag, what, exp, act);
    endtask

    always @(negedge clk) begin
        string tag;
        if (rst) begin
            op_sh    = '{default: '0};
            ch_sh    = '{default: '0};
            kon_sh   = '{default: 1'b0};
            exp_slot = '0;
            pend     = 1'b0;
            csm_left = 0;
        end else begin
            tag = $sformatf("%s slot %0d", test_name, exp_slot);
            check_slot(tag, exp_slot, cycles);
            check_flag(tag, "zero", exp_slot == 5'd0, zero);
            check_flag(tag, "half", exp_slot[3:0] == 4'd0, half);
            check_flag(tag, "busy", pend, busy);
            check_keyon(tag, csm_left > 0 || kon_sh[exp_slot], keyon);
            check_op(tag, exp_op(exp_slot), op_par);
            check_ch(tag, exp_ch(exp_slot), ch_par);
            check_route(tag, exp_route(exp_ch(exp_slot).con, exp_slot[4:3]), route);
            if (wr && !pend) begin                 // Effect of the coming rising edge
                if (wr_req.field == KEYON) begin
                    apply_write(wr_req);
                end else begin
                    pend     = 1'b1;
                    pend_req = wr_req;
                end
            end else if (pend && cen && hits_head(pend_req, exp_slot)) begin
                apply_write(pend_req);
                pend = 1'b0;
            end
            if (overflow_a && csm) begin
                csm_left = `FM_SLOTS;
            end else if (csm_left > 0 && cen) begin
                csm_left--;
            end
            if (cen) begin
                exp_slot++;
            end
        end
    end

    task automatic issue_wr(reg_field_e f, opsel_t o, chan_t c, logic [7:0] d);
        @(posedge clk);
        #10;
        wr     = 1'b1;
        wr_req = '{field: f, op: o, ch: c, data: d};
        @(posedge clk);
        #10;
        wr = 1'b0;
    endtask

    // Counts cen cycles until busy falls
    task automatic wait_idle(int limit);
        int n;
        n = 0;
        while (busy) begin
            @(negedge clk);
            if (busy && cen) begin
                n++;
            end
        end
        if (n > limit) begin
            lat_errs++;
            $display("ERROR %s: busy cen cycles expected at most %0d, got %0d", test_name, limit, n);
        end
    endtask

    task automatic wait_cen(int n);
        int k;
        k = 0;
        while (k < n) begin
            @(negedge clk);
            if (cen) begin
                k++;
            end
        end
    endtask

    initial begin
        reg_field_e  f;
        logic [31:0] r;
        rst        = 1'b1;
        wr         = 1'b0;
        wr_req     = '0;
        csm        = 1'b0;
        overflow_a = 1'b0;
        repeat (3) @(posedge clk);
        #10;
        rst       = 1'b0;
        test_name = "count";
        wait_cen(40);
        test_name = "op_write";
        repeat (24) begin
            r = $random(seed);
            f = reg_field_e'(int'(DT1_MUL) + int'(r[7:0]) % 6);
            issue_wr(f, r[9:8], r[12:10], r[23:16]);
            wait_idle(`FM_SLOTS);
        end
        wait_cen(64);
        test_name = "ch_write";
        repeat (12) begin
            r = $random(seed);
            f = reg_field_e'(int'(r[1:0]));       // Channel fields lead the enum
            issue_wr(f, r[9:8], r[12:10], r[23:16]);
            wait_idle(`FM_CHANNELS);
        end
        wait_cen(16);
        test_name = "route";
        for (int a = 0; a < 8; a++) begin
            issue_wr(RL_FB_CON, 2'd0, 3'd5, {5'(a * 5), 3'(a)});
            wait_idle(`FM_CHANNELS);
            wait_cen(`FM_SLOTS);                  // All four operators of channel 5
        end
        test_name = "keyon";
        repeat (8) begin
            r = $random(seed);
            issue_wr(KEYON, 2'd0, 3'd0, {1'b0, r[6:0]});
        end
        issue_wr(KEYON, 2'd0, 3'd0, 8'h07);      // Channel 7 all off
        test_name = "busy_drop";
        issue_wr(TL, 2'd3, 3'd6, 8'h2a);
        wr     = 1'b1;                            // Lands while busy is high
        wr_req = '{field: KEYON, op: 2'd0, ch: 3'd0, data: 8'h7f};
        @(posedge clk);
        #10;
        wr = 1'b0;
        wait_idle(`FM_SLOTS);
        wait_cen(`FM_SLOTS);
        test_name = "csm";
        @(posedge clk);
        #10;
        csm        = 1'b1;
        overflow_a = 1'b1;
        @(posedge clk);
        #10;
        overflow_a = 1'b0;
        wait_cen(64);
        $display("Errors: %0d value, %0d latency, %0d assertion", val_errs, lat_errs,
                 i_fm_reg_top.u_sva.fail_cnt);
        if (val_errs + lat_errs + i_fm_reg_top.u_sva.fail_cnt == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+hw
hw/fm_reg_pkg.sv
hw/fm_slot_ctrl.sv
hw/fm_op_regs.sv
hw/fm_ch_regs.sv
hw/fm_keyon.sv
hw/fm_mod_route.sv
hw/fm_reg_top.sv
tb/fm_reg_sva.sv
tb/fm_reg_tb.sv

// File: Bender.yml
package:
  name: fm_reg

sources:
  - include_dirs:
      - hw
    files:
      - hw/fm_reg_pkg.sv
      - hw/fm_slot_ctrl.sv
      - hw/fm_op_regs.sv
      - hw/fm_ch_regs.sv
      - hw/fm_keyon.sv
      - hw/fm_mod_route.sv
      - hw/fm_reg_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tb/fm_reg_sva.sv
      - tb/fm_reg_tb.sv
